//--- rtl/mesi_isc_pkg.sv
`default_nettype none

package mesi_isc_pkg;

  // ==================================================
  // System sizes
  // ==================================================
  localparam int CPU_COUNT      = 4;
  localparam int ADDR_WIDTH     = 32;
  // Default depth of the request and broadcast FIFOs
  localparam int FIFO_SIZE      = 4;
  localparam int FIFO_SIZE_LOG2 = 2;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Wide enough to index any of the CPUs
  typedef logic [1:0]            cpu_id_t;

  // ==================================================
  // Main bus commands from the CPUs
  // ==================================================
  typedef logic [2:0] mbus_cmd_t;
  localparam mbus_cmd_t MBUS_CMD_NOP      = 3'd0;
  localparam mbus_cmd_t MBUS_CMD_WR       = 3'd1;
  localparam mbus_cmd_t MBUS_CMD_RD       = 3'd2;
  localparam mbus_cmd_t MBUS_CMD_WR_BROAD = 3'd3;
  localparam mbus_cmd_t MBUS_CMD_RD_BROAD = 3'd4;

  // Coherence bus commands towards the CPUs
  typedef logic [2:0] cbus_cmd_t;
  localparam cbus_cmd_t CBUS_CMD_NOP      = 3'd0;
  localparam cbus_cmd_t CBUS_CMD_WR_SNOOP = 3'd1;
  localparam cbus_cmd_t CBUS_CMD_RD_SNOOP = 3'd2;
  localparam cbus_cmd_t CBUS_CMD_EN_WR    = 3'd3;
  localparam cbus_cmd_t CBUS_CMD_EN_RD    = 3'd4;

  // ==================================================
  // Broadcast request entries
  // ==================================================
  typedef logic [1:0] breq_type_t;
  localparam breq_type_t BREQ_TYPE_NOP = 2'd0;
  localparam breq_type_t BREQ_TYPE_WR  = 2'd1;
  localparam breq_type_t BREQ_TYPE_RD  = 2'd2;

  // Request FIFO entry is {type, address}
  localparam int BREQ_WIDTH  = $bits(breq_type_t) + ADDR_WIDTH;
  // Broadcast FIFO entry is {type, source id, address}
  localparam int BROAD_WIDTH = $bits(breq_type_t) + $bits(cpu_id_t) + ADDR_WIDTH;

  // Broadcast controller states
  typedef enum logic [1:0] {
    BROAD_IDLE,
    BROAD_SNOOP,
    BROAD_ENABLE
  } broad_state_t;

endpackage

`default_nettype wire

//--- rtl/mesi_isc_basic_fifo.sv
`default_nettype none

module mesi_isc_basic_fifo #(
  parameter int DATA_WIDTH     = 32,
  parameter int FIFO_SIZE      = 4,
  parameter int FIFO_SIZE_LOG2 = 2
) (
  input  wire                   clk,
  input  wire                   rst,
  // Push data_i at this edge
  input  wire                   wr_i,
  // Drop the head entry at this edge
  input  wire                   rd_i,
  input  wire  [DATA_WIDTH-1:0] data_i,
  // Sampled head entry, valid while not empty
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  status_empty_o,
  output logic                  status_full_o
);

  // Storage
  logic [DATA_WIDTH-1:0]     entry [FIFO_SIZE];
  logic [FIFO_SIZE_LOG2-1:0] ptr_wr;
  logic [FIFO_SIZE_LOG2-1:0] ptr_rd;
  logic [FIFO_SIZE_LOG2-1:0] ptr_rd_plus_1;
  // Used entries, wraps to 0 both when empty and when full
  logic [FIFO_SIZE_LOG2-1:0] fifo_depth;
  logic                      depth_inc;
  logic                      depth_dec;

  // ==================================================
  // Write side
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (wr_i)
      entry[ptr_wr] <= data_i;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ptr_wr <= '0;
    else if (wr_i)
      ptr_wr <= ptr_wr + 1'b1;
  end

  // ==================================================
  // Read side
  // ==================================================
  assign ptr_rd_plus_1 = ptr_rd + 1'b1;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ptr_rd <= '0;
    else if (rd_i)
      ptr_rd <= ptr_rd + 1'b1;
  end

  // Head register always holds entry[ptr_rd] one cycle ahead
  always_ff @(posedge clk)
  begin
    // Empty: catch the write data so it is at the head next cycle
    if (status_empty_o)
      data_o <= data_i;
    // Single entry popped while the next one is written in the same edge
    else if (rd_i && wr_i && (ptr_rd_plus_1 == ptr_wr))
      data_o <= data_i;
    // Pop moves the head to the following entry
    else if (rd_i)
      data_o <= entry[ptr_rd_plus_1];
    else
      data_o <= entry[ptr_rd];
  end

  // ==================================================
  // Status flags
  // ==================================================
  // Simultaneous write and read leaves the depth unchanged
  assign depth_inc  = wr_i & ~rd_i;
  assign depth_dec  = ~wr_i & rd_i;
  assign fifo_depth = ptr_wr - ptr_rd;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      status_empty_o <= 1'b1;
    // Last entry leaves
    else if ((fifo_depth == FIFO_SIZE_LOG2'(1)) && depth_dec)
      status_empty_o <= 1'b1;
    // First entry arrives
    else if ((fifo_depth == '0) && status_empty_o && depth_inc)
      status_empty_o <= 1'b0;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      status_full_o <= 1'b0;
    // Last free slot taken
    else if ((fifo_depth == FIFO_SIZE_LOG2'(FIFO_SIZE - 1)) && depth_inc)
      status_full_o <= 1'b1;
    // A slot frees up
    else if ((fifo_depth == '0) && status_full_o && depth_dec)
      status_full_o <= 1'b0;
  end

  // Producer must respect full, consumer must respect empty
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(status_full_o && depth_inc));
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    !(status_empty_o && rd_i));

endmodule

`default_nettype wire

//--- rtl/mesi_isc_breq_fifos.sv
`default_nettype none

module mesi_isc_breq_fifos
  import mesi_isc_pkg::*;
(
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire  mbus_cmd_t [CPU_COUNT-1:0]      mbus_cmd_i,
  input  wire  addr_t     [CPU_COUNT-1:0]      mbus_addr_i,
  // One-hot or zero pop from the arbiter
  input  wire  [CPU_COUNT-1:0]                 breq_pop_i,
  output logic [CPU_COUNT-1:0]                 mbus_ack_o,
  output logic [CPU_COUNT-1:0]                 breq_empty_o,
  output logic [CPU_COUNT-1:0][BREQ_WIDTH-1:0] breq_head_o
);

  breq_type_t [CPU_COUNT-1:0] breq_type;
  logic       [CPU_COUNT-1:0] breq_full;
  logic       [CPU_COUNT-1:0] breq_wr;

  // ==================================================
  // Command decode
  // ==================================================
  // Only broadcasts are coherence traffic, the rest go to memory
  always_comb
  begin
    for (int c = 0; c < CPU_COUNT; c++)
    begin
      case (mbus_cmd_i[c])
        MBUS_CMD_WR_BROAD: breq_type[c] = BREQ_TYPE_WR;
        MBUS_CMD_RD_BROAD: breq_type[c] = BREQ_TYPE_RD;
        MBUS_CMD_NOP,
        MBUS_CMD_WR,
        MBUS_CMD_RD:       breq_type[c] = BREQ_TYPE_NOP;
        default:           breq_type[c] = BREQ_TYPE_NOP;
      endcase
    end
  end

  // Accept whenever there is room, ack and write share the edge
  always_comb
  begin
    for (int c = 0; c < CPU_COUNT; c++)
      breq_wr[c] = (breq_type[c] != BREQ_TYPE_NOP) && !breq_full[c];
  end

  assign mbus_ack_o = breq_wr;

  // ==================================================
  // One request FIFO per CPU
  // ==================================================
  for (genvar c = 0; c < CPU_COUNT; c++)
  begin : g_cpu
    mesi_isc_basic_fifo #(
      .DATA_WIDTH     (BREQ_WIDTH),
      .FIFO_SIZE      (FIFO_SIZE),
      .FIFO_SIZE_LOG2 (FIFO_SIZE_LOG2)
    ) i_breq_fifo (
      .clk            (clk),
      .rst            (rst),
      .wr_i           (breq_wr[c]),
      .rd_i           (breq_pop_i[c]),
      .data_i         ({breq_type[c], mbus_addr_i[c]}),
      .data_o         (breq_head_o[c]),
      .status_empty_o (breq_empty_o[c]),
      .status_full_o  (breq_full[c])
    );
  end

endmodule

`default_nettype wire

//--- rtl/mesi_isc_breq_arbiter.sv
`default_nettype none

module mesi_isc_breq_arbiter
  import mesi_isc_pkg::*;
(
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire  [CPU_COUNT-1:0]                 breq_empty_i,
  input  wire  [CPU_COUNT-1:0][BREQ_WIDTH-1:0] breq_head_i,
  input  wire                                  broad_full_i,
  output logic [CPU_COUNT-1:0]                 breq_pop_o,
  output logic                                 broad_push_o,
  output logic [BROAD_WIDTH-1:0]               broad_entry_o
);

  // CPU served last, search starts right after it
  cpu_id_t    last_grant;
  cpu_id_t    grant_id;
  logic       grant_found;
  breq_type_t head_type;
  addr_t      head_addr;

  // ==================================================
  // Round-robin search
  // ==================================================
  always_comb
  begin
    grant_found = 1'b0;
    grant_id    = last_grant;
    // Offset CPU_COUNT wraps back to last_grant itself, checked last
    for (int k = 1; k <= CPU_COUNT; k++)
    begin
      if (!grant_found && !breq_empty_i[last_grant + cpu_id_t'(k)])
      begin
        grant_found = 1'b1;
        grant_id    = last_grant + cpu_id_t'(k);
      end
    end
  end

  // Move one request per cycle unless the broadcast FIFO is full
  assign broad_push_o = grant_found && !broad_full_i;
  assign breq_pop_o   = broad_push_o ? (CPU_COUNT'(1) << grant_id) : '0;

  // Tag the head entry with its source
  assign head_type     = breq_head_i[grant_id][BREQ_WIDTH-1 -: $bits(breq_type_t)];
  assign head_addr     = breq_head_i[grant_id][ADDR_WIDTH-1:0];
  assign broad_entry_o = {head_type, grant_id, head_addr};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      last_grant <= cpu_id_t'(CPU_COUNT - 1);
    else if (broad_push_o)
      last_grant <= grant_id;
  end

  // Pops are exclusive and only ever hit a FIFO that holds data
  a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(breq_pop_o) && ((breq_pop_o & breq_empty_i) == '0));

endmodule

`default_nettype wire

//--- rtl/mesi_isc_broad_cntl.sv
`default_nettype none

module mesi_isc_broad_cntl
  import mesi_isc_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         broad_push_i,
  input  wire  [BROAD_WIDTH-1:0]      broad_entry_i,
  // One-cycle ack per CPU
  input  wire  [CPU_COUNT-1:0]        cbus_ack_i,
  output logic                        broad_full_o,
  output cbus_cmd_t [CPU_COUNT-1:0]   cbus_cmd_o,
  output addr_t                       cbus_addr_o
);

  logic [BROAD_WIDTH-1:0] broad_head;
  logic                   broad_empty;
  logic                   broad_pop;

  broad_state_t state;
  // CPU that currently holds the command
  cpu_id_t      target;
  // Snoops acknowledged so far
  cpu_id_t      snoop_cnt;

  // Broadcast in flight
  breq_type_t   cur_type;
  cpu_id_t      cur_src;
  addr_t        cur_addr;

  logic [CPU_COUNT-1:0] cmd_active;

  // ==================================================
  // Broadcast FIFO
  // ==================================================
  mesi_isc_basic_fifo #(
    .DATA_WIDTH     (BROAD_WIDTH),
    .FIFO_SIZE      (FIFO_SIZE),
    .FIFO_SIZE_LOG2 (FIFO_SIZE_LOG2)
  ) i_broad_fifo (
    .clk            (clk),
    .rst            (rst),
    .wr_i           (broad_push_i),
    .rd_i           (broad_pop),
    .data_i         (broad_entry_i),
    .data_o         (broad_head),
    .status_empty_o (broad_empty),
    .status_full_o  (broad_full_o)
  );

  // Take a new entry only when the bus is free
  assign broad_pop = (state == BROAD_IDLE) && !broad_empty;

  // ==================================================
  // Sequencer
  // ==================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= BROAD_IDLE;
      target    <= '0;
      snoop_cnt <= '0;
    end
    else
    begin
      case (state)
        BROAD_IDLE:
          if (broad_pop)
          begin
            // First snoop goes to the CPU after the source
            target    <= broad_head[ADDR_WIDTH +: $bits(cpu_id_t)] + 1'b1;
            snoop_cnt <= '0;
            state     <= BROAD_SNOOP;
          end
        BROAD_SNOOP:
          if (cbus_ack_i[target])
          begin
            // Stepping past the last peer lands back on the source
            target    <= target + 1'b1;
            snoop_cnt <= snoop_cnt + 1'b1;
            if (snoop_cnt == cpu_id_t'(CPU_COUNT - 2))
              state <= BROAD_ENABLE;
          end
        BROAD_ENABLE:
          if (cbus_ack_i[cur_src])
            state <= BROAD_IDLE;
        default:
          state <= BROAD_IDLE;
      endcase
    end
  end

  // Entry fields captured at the pop
  always_ff @(posedge clk)
  begin
    if (broad_pop)
      {cur_type, cur_src, cur_addr} <= broad_head;
  end

  // Command decode, one CPU at a time
  always_comb
  begin
    cbus_cmd_o = '{default: CBUS_CMD_NOP};
    case (state)
      BROAD_SNOOP:
        cbus_cmd_o[target] = (cur_type == BREQ_TYPE_WR) ? CBUS_CMD_WR_SNOOP
                                                        : CBUS_CMD_RD_SNOOP;
      BROAD_ENABLE:
        cbus_cmd_o[cur_src] = (cur_type == BREQ_TYPE_WR) ? CBUS_CMD_EN_WR
                                                         : CBUS_CMD_EN_RD;
      default:
        cbus_cmd_o = '{default: CBUS_CMD_NOP};
    endcase
  end

  assign cbus_addr_o = cur_addr;

  always_comb
  begin
    for (int c = 0; c < CPU_COUNT; c++)
      cmd_active[c] = (cbus_cmd_o[c] != CBUS_CMD_NOP);
  end

  // Single coherence command on the bus
  a_one_cmd: assert property (@(posedge clk) disable iff (rst)
    $onehot0(cmd_active));

endmodule

`default_nettype wire

//--- rtl/mesi_isc_top.sv
`default_nettype none

module mesi_isc_top
  import mesi_isc_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst,
  // Main bus side, one command and address per CPU
  input  wire  mbus_cmd_t [CPU_COUNT-1:0] mbus_cmd_i,
  input  wire  addr_t     [CPU_COUNT-1:0] mbus_addr_i,
  // Coherence bus acks, one pulse per CPU
  input  wire  [CPU_COUNT-1:0]        cbus_ack_i,
  output logic [CPU_COUNT-1:0]        mbus_ack_o,
  output cbus_cmd_t [CPU_COUNT-1:0]   cbus_cmd_o,
  output addr_t                       cbus_addr_o
);

  // ==================================================
  // Request FIFOs to arbiter
  // ==================================================
  logic [CPU_COUNT-1:0]                 breq_empty;
  logic [CPU_COUNT-1:0][BREQ_WIDTH-1:0] breq_head;
  logic [CPU_COUNT-1:0]                 breq_pop;

  // Arbiter to broadcast controller
  logic                   broad_push;
  logic [BROAD_WIDTH-1:0] broad_entry;
  logic                   broad_full;

  mesi_isc_breq_fifos i_breq_fifos (
    .clk          (clk),
    .rst          (rst),
    .mbus_cmd_i   (mbus_cmd_i),
    .mbus_addr_i  (mbus_addr_i),
    .breq_pop_i   (breq_pop),
    .mbus_ack_o   (mbus_ack_o),
    .breq_empty_o (breq_empty),
    .breq_head_o  (breq_head)
  );

  mesi_isc_breq_arbiter i_breq_arbiter (
    .clk           (clk),
    .rst           (rst),
    .breq_empty_i  (breq_empty),
    .breq_head_i   (breq_head),
    .broad_full_i  (broad_full),
    .breq_pop_o    (breq_pop),
    .broad_push_o  (broad_push),
    .broad_entry_o (broad_entry)
  );

  mesi_isc_broad_cntl i_broad_cntl (
    .clk           (clk),
    .rst           (rst),
    .broad_push_i  (broad_push),
    .broad_entry_i (broad_entry),
    .cbus_ack_i    (cbus_ack_i),
    .broad_full_o  (broad_full),
    .cbus_cmd_o    (cbus_cmd_o),
    .cbus_addr_o   (cbus_addr_o)
  );

endmodule

`default_nettype wire

//--- verif/mesi_isc_tb_model.svh
`ifndef MESI_ISC_TB_MODEL_SVH
`define MESI_ISC_TB_MODEL_SVH

// ==================================================
// Expected requests, one queue per CPU
// ==================================================
typedef struct packed {
  breq_type_t  kind;
  addr_t       addr;
  // Sequences begun when the request was accepted
  logic [31:0] stamp;
} exp_req_t;

exp_req_t exp_q [CPU_COUNT][$];

localparam int NUM_TRANS   = 200;
localparam int STALL_START = 300;
localparam int STALL_LEN   = 40;

// Request FIFOs, broadcast FIFO and the entry being sequenced
localparam int MAX_IN_FLIGHT  = CPU_COUNT * FIFO_SIZE + FIFO_SIZE + 1;
localparam int FAIR_BOUND     = FIFO_SIZE + 1 + FIFO_SIZE * (CPU_COUNT - 1) + FIFO_SIZE;
// Four commands of at most 7 cycles each plus slack, per transaction
localparam int TIMEOUT_CYCLES = NUM_TRANS * (CPU_COUNT * 7 + 10) + STALL_LEN;

// Sequence currently walking the coherence bus
logic        seq_active;
cpu_id_t     seq_src;
breq_type_t  seq_kind;
addr_t       seq_addr;
int          seq_step;
logic [31:0] seq_started;
logic [31:0] lcg_state;

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Upper bits have the longer period
function automatic int rand_below(input int n);
  logic [31:0] r;
  r = next_rand();
  return int'(r[31:16]) % n;
endfunction

function automatic breq_type_t broad_kind(input mbus_cmd_t cmd);
  if (cmd == MBUS_CMD_WR_BROAD)
    return BREQ_TYPE_WR;
  if (cmd == MBUS_CMD_RD_BROAD)
    return BREQ_TYPE_RD;
  return BREQ_TYPE_NOP;
endfunction

// Snoops go to source+1 up to source+3, then the enable back to the source
function automatic cpu_id_t expected_holder(input int step);
  return (step < CPU_COUNT - 1) ? seq_src + cpu_id_t'(step + 1) : seq_src;
endfunction

function automatic cbus_cmd_t expected_cmd(input int step);
  if (step < CPU_COUNT - 1)
    return (seq_kind == BREQ_TYPE_WR) ? CBUS_CMD_WR_SNOOP : CBUS_CMD_RD_SNOOP;
  return (seq_kind == BREQ_TYPE_WR) ? CBUS_CMD_EN_WR : CBUS_CMD_EN_RD;
endfunction

// Accepted requests whose sequence has not finished
function automatic int outstanding();
  int n;
  n = seq_active ? 1 : 0;
  for (int c = 0; c < CPU_COUNT; c++)
    n += exp_q[c].size();
  return n;
endfunction

`endif

//--- verif/mesi_isc_tb.sv
`default_nettype none

module mesi_isc_tb
  import mesi_isc_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  `include "mesi_isc_tb_model.svh"

  logic                      clk;
  logic                      rst;
  mbus_cmd_t [CPU_COUNT-1:0] mbus_cmd;
  addr_t     [CPU_COUNT-1:0] mbus_addr;
  logic      [CPU_COUNT-1:0] cbus_ack;
  logic      [CPU_COUNT-1:0] mbus_ack;
  cbus_cmd_t [CPU_COUNT-1:0] cbus_cmd;
  addr_t                     cbus_addr;

  // Values applied at the next drive point
  mbus_cmd_t [CPU_COUNT-1:0] cmd_nxt;
  addr_t     [CPU_COUNT-1:0] addr_nxt;
  logic      [CPU_COUNT-1:0] ack_nxt;
  // Broadcast still waiting for its main-bus ack
  logic      [CPU_COUNT-1:0] cpu_busy;
  // Bus at the previous sample point
  cbus_cmd_t [CPU_COUNT-1:0] prev_cmd;
  addr_t                     prev_addr;
  logic                      prev_active;
  logic      [CPU_COUNT-1:0] ack_last;
  int                        err_cnt;
  int                        issued;
  int                        accepted;
  int                        ack_wait;
  int                        stall_left;
  int                        cycle_cnt;
  int                        loop_cnt;

  mesi_isc_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .mbus_cmd_i  (mbus_cmd),
    .mbus_addr_i (mbus_addr),
    .cbus_ack_i  (cbus_ack),
    .mbus_ack_o  (mbus_ack),
    .cbus_cmd_o  (cbus_cmd),
    .cbus_addr_o (cbus_addr)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    assert (cond)
    else
    begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s", $time, what);
    end
  endtask

  // Broadcasts 70 percent of the time, memory traffic otherwise
  task automatic pick_command(input int c);
    int r;
    r = rand_below(10);
    addr_nxt[c] = next_rand();
    if (r < 7)
    begin
      cmd_nxt[c]  = (rand_below(2) == 0) ? MBUS_CMD_WR_BROAD : MBUS_CMD_RD_BROAD;
      cpu_busy[c] = 1'b1;
    end
    else
    begin
      case (rand_below(3))
        0:       cmd_nxt[c] = MBUS_CMD_NOP;
        1:       cmd_nxt[c] = MBUS_CMD_WR;
        default: cmd_nxt[c] = MBUS_CMD_RD;
      endcase
    end
    issued++;
  endtask

  // ==================================================
  // Coherence bus monitor and ack responder
  // ==================================================
  task automatic observe_bus();
    logic [CPU_COUNT-1:0] consumed;
    int                   active_cnt;
    cpu_id_t              holder;
    exp_req_t             req;
    consumed   = ack_last;
    active_cnt = 0;
    holder     = '0;
    for (int c = 0; c < CPU_COUNT; c++)
    begin
      if (cbus_cmd[c] != CBUS_CMD_NOP)
      begin
        active_cnt++;
        holder = cpu_id_t'(c);
      end
    end
    expect_true(active_cnt <= 1, "more than one CPU holds a coherence command");
    // No ack taken, so the bus must not move
    if (prev_active && consumed == '0)
      expect_true(cbus_cmd == prev_cmd && cbus_addr == prev_addr,
                  "coherence command changed without an acknowledge");
    // Ack of the enable closes the sequence
    if (consumed != '0 && seq_active && seq_step == CPU_COUNT - 1)
      seq_active = 1'b0;
    if (active_cnt == 1 && (!prev_active || consumed != '0))
    begin
      if (!seq_active)
      begin
        // First snoop names the source as the CPU before it
        seq_src    = holder - 1'b1;
        seq_active = 1'b1;
        seq_step   = 0;
        expect_true(exp_q[seq_src].size() != 0, "coherence sequence without an accepted request");
        if (exp_q[seq_src].size() != 0)
        begin
          req      = exp_q[seq_src].pop_front();
          seq_kind = req.kind;
          seq_addr = req.addr;
          expect_true(seq_started - req.stamp <= FAIR_BOUND,
                      "request overtaken by too many other sequences");
        end
        seq_started++;
      end
      else
        seq_step++;
      compare_value("cbus_cmd_o target", holder, expected_holder(seq_step));
      compare_value($sformatf("cbus_cmd_o[%0d]", holder), cbus_cmd[holder],
                    expected_cmd(seq_step));
      compare_value("cbus_addr_o", cbus_addr, seq_addr);
      ack_wait = rand_below(6);
    end
    else if (consumed != '0 && seq_active)
    begin
      expect_true(1'b0, "coherence sequence stopped before the enable");
      seq_active = 1'b0;
    end
    prev_active = (active_cnt != 0);
    prev_cmd    = cbus_cmd;
    prev_addr   = cbus_addr;
    ack_last    = cbus_ack;
    // One-cycle ack pulse after the random delay, none while stalled
    ack_nxt = '0;
    if (active_cnt == 1 && cbus_ack == '0 && stall_left == 0)
    begin
      if (ack_wait == 0)
        ack_nxt[holder] = 1'b1;
      else
        ack_wait--;
    end
  endtask

  // Main-bus acks and the next CPU commands
  task automatic observe_cpus();
    exp_req_t req;
    for (int c = 0; c < CPU_COUNT; c++)
    begin
      if (broad_kind(mbus_cmd[c]) != BREQ_TYPE_NOP)
      begin
        if (mbus_ack[c])
        begin
          req.kind  = broad_kind(mbus_cmd[c]);
          req.addr  = mbus_addr[c];
          req.stamp = seq_started;
          exp_q[c].push_back(req);
          accepted++;
          cpu_busy[c] = 1'b0;
        end
      end
      else
        compare_value($sformatf("mbus_ack_o[%0d]", c), mbus_ack[c], 1'b0);
    end
    expect_true(outstanding() <= MAX_IN_FLIGHT, "more requests accepted than the FIFOs hold");
    for (int c = 0; c < CPU_COUNT; c++)
    begin
      if (!cpu_busy[c])
      begin
        if (issued < NUM_TRANS)
          pick_command(c);
        else
          cmd_nxt[c] = MBUS_CMD_NOP;
      end
    end
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      err_cnt++;
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d, sequences: %0d, accepted: %0d", err_cnt, seq_started, accepted);
      $display("Done: errors found");
      $finish;
    end
  end

  // ==================================================
  // Reset, then one loop iteration per clock
  // ==================================================
  initial
  begin
    lcg_state   = 32'h5b7c;
    seq_active  = 1'b0;
    seq_step    = 0;
    seq_started = '0;
    err_cnt     = 0;
    issued      = 0;
    accepted    = 0;
    ack_wait    = 0;
    stall_left  = 0;
    cycle_cnt   = 0;
    loop_cnt    = 0;
    cpu_busy    = '0;
    prev_active = 1'b0;
    prev_cmd    = {CPU_COUNT{CBUS_CMD_NOP}};
    prev_addr   = '0;
    ack_last    = '0;
    rst         = 1'b1;
    mbus_cmd    = {CPU_COUNT{MBUS_CMD_NOP}};
    mbus_addr   = '0;
    cbus_ack    = '0;
    cmd_nxt     = {CPU_COUNT{MBUS_CMD_NOP}};
    addr_nxt    = '0;
    ack_nxt     = '0;
    repeat (3) @(posedge clk);
    #1;
    expect_true(cbus_cmd == {CPU_COUNT{CBUS_CMD_NOP}} && mbus_ack == '0,
                "coherence command or main-bus ack active in reset");
    rst = 1'b0;
    // Run until every accepted request has had its sequence and the bus is idle
    while (!(issued == NUM_TRANS && cpu_busy == '0 && seq_started == accepted &&
             !seq_active && !prev_active))
    begin
      @(negedge clk);
      // Withhold every coherence ack for a while to fill the FIFOs
      if (loop_cnt == STALL_START)
        stall_left = STALL_LEN;
      else if (stall_left > 0)
        stall_left--;
      observe_bus();
      observe_cpus();
      @(posedge clk);
      #1;
      mbus_cmd  = cmd_nxt;
      mbus_addr = addr_nxt;
      cbus_ack  = ack_nxt;
      loop_cnt++;
    end
    expect_true(outstanding() == 0, "expected queues not empty at the end of the run");
    $display("Errors: %0d, sequences: %0d, accepted: %0d", err_cnt, seq_started, accepted);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- mesi_isc_top.f
+incdir+verif
rtl/mesi_isc_pkg.sv
rtl/mesi_isc_basic_fifo.sv
rtl/mesi_isc_breq_fifos.sv
rtl/mesi_isc_breq_arbiter.sv
rtl/mesi_isc_broad_cntl.sv
rtl/mesi_isc_top.sv
verif/mesi_isc_tb.sv

//--- Bender.yml
package:
  name: mesi_isc

sources:
  - files:
      - rtl/mesi_isc_pkg.sv
      - rtl/mesi_isc_basic_fifo.sv
      - rtl/mesi_isc_breq_fifos.sv
      - rtl/mesi_isc_breq_arbiter.sv
      - rtl/mesi_isc_broad_cntl.sv
      - rtl/mesi_isc_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/mesi_isc_tb.sv
